//--- verilog/edu_core_pkg.sv
/*
 * Widths, encodings and opcode patterns shared by every stage of the core.
 * Only the classes matched below are legal. Any other word raises the error.
 * Size codes follow the A64 load/store size field. Halfword is not supported.
 */
package edu_core_pkg;

	// ------------------------------------------------------------------------
	// Datapath types
	// ------------------------------------------------------------------------

	// One 64-bit datum or byte address
	typedef logic [63:0] word_t;
	typedef logic [31:0] instr_t;
	// Index 31 is the zero register
	typedef logic [4:0]  reg_idx_t;
	// Flag order N, Z, C, V from bit 3 down
	typedef logic [3:0]  nzcv_t;
	typedef logic [1:0]  mem_size_t;
	typedef logic [1:0]  alu_cmd_t;

	// Access sizes, same codes as instr[31:30] of LDR/STR
	localparam mem_size_t SIZE_B = 2'b00;
	localparam mem_size_t SIZE_W = 2'b10;
	localparam mem_size_t SIZE_D = 2'b11;

	// ALU commands
	// Logical codes equal the opc field of AND/ORR/EOR
	// Subtract is ALU_ADD with B inverted and carry in set
	localparam alu_cmd_t ALU_AND = 2'b00;
	localparam alu_cmd_t ALU_ORR = 2'b01;
	localparam alu_cmd_t ALU_EOR = 2'b10;
	localparam alu_cmd_t ALU_ADD = 2'b11;

	// HINT #0
	localparam instr_t     INST_NOP = 32'hd503_201f;
	localparam reg_idx_t   REG_ZERO = 5'd31;
	localparam logic [3:0] COND_AL  = 4'b1110;

	// ------------------------------------------------------------------------
	// Opcode classes, a word belongs to a class when (word & MASK) == MATCH
	// ------------------------------------------------------------------------

	// ADD/ADDS/SUB/SUBS #imm12, sh must be zero
	localparam instr_t MASK_ADDSUB_IMM  = 32'h1fc0_0000;
	localparam instr_t MATCH_ADDSUB_IMM = 32'h1100_0000;
	// ADD/ADDS/SUB/SUBS register, LSL #0 only
	localparam instr_t MASK_ADDSUB_REG  = 32'h1fe0_fc00;
	localparam instr_t MATCH_ADDSUB_REG = 32'h0b00_0000;
	// AND/ORR/EOR register, no shift, no inverted forms
	localparam instr_t MASK_LOGIC_REG   = 32'h1fe0_fc00;
	localparam instr_t MATCH_LOGIC_REG  = 32'h0a00_0000;
	// LDR/STR unsigned scaled offset, opc[1] clear so no sign-extending loads
	localparam instr_t MASK_LDST_UIMM   = 32'h3f80_0000;
	localparam instr_t MATCH_LDST_UIMM  = 32'h3900_0000;
	// B imm26
	localparam instr_t MASK_B           = 32'hfc00_0000;
	localparam instr_t MATCH_B          = 32'h1400_0000;
	// B.cond imm19
	localparam instr_t MASK_BCOND       = 32'hff00_0010;
	localparam instr_t MATCH_BCOND      = 32'h5400_0000;

endpackage

//--- verilog/fetch_stage.sv
/*
 * PC, next-PC selection and the core enable run.
 * A taken branch loads its target at the end of its execute cycle, so the
 * two fetches already issued behind it complete as delay slots.
 */
`timescale 1ns/1ns

module fetch_stage import edu_core_pkg::*; (
	input  logic  clk,
	input  logic  nreset,
	input  logic  clk_en,
	input  logic  error_flag,
	input  logic  branch_taken,
	input  word_t branch_target,
	output logic  run,
	output word_t pc,
	output word_t instr_addr,
	output logic  instr_en
);

	logic  nreset_sync;
	// Address of the fetch going out this cycle
	word_t fetch_pc;

	// Reset release, seen on the first enabled edge
	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			nreset_sync <= 1'b0;
		end else if (clk_en) begin
			nreset_sync <= 1'b1;
		end
	end

	// Stalled by clk_en, stopped for good by a decode error
	assign run = clk_en && !error_flag && nreset_sync;

	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			fetch_pc <= '0;
		end else if (run) begin
			fetch_pc <= branch_taken ? branch_target : fetch_pc + word_t'(4);
		end
	end

	// Follows instr_data into decode, one cycle behind the address
	always_ff @(posedge clk) begin
		if (run) begin
			pc <= fetch_pc;
		end
	end

	assign instr_addr = fetch_pc;
	// Stays high through stalls
	assign instr_en   = nreset_sync;

endmodule

//--- verilog/decode_stage.sv
/*
 * Instruction decode and the decode-to-execute registers.
 * Any word outside the supported classes raises error_flag until reset.
 * Register values are taken as read, with no forwarding from execute.
 */
`timescale 1ns/1ns

module decode_stage import edu_core_pkg::*; (
	input  logic       clk,
	input  logic       nreset,
	input  logic       run,
	input  instr_t     instr_data,
	input  word_t      fetch_pc,
	input  word_t      rd_n,
	input  word_t      rd_m,
	input  word_t      rd_a,
	output reg_idx_t   rd_idx_n,
	output reg_idx_t   rd_idx_m,
	output reg_idx_t   rd_idx_a,
	output word_t      op_n,
	output word_t      op_m,
	output word_t      op_a,
	output alu_cmd_t   alu_cmd,
	output logic       invert_b,
	output logic       sf,
	output logic       set_flags,
	output logic [3:0] cond,
	output logic       is_branch,
	output logic       mem_read,
	output logic       mem_write,
	output mem_size_t  mem_size,
	output logic       wr_en,
	output reg_idx_t   wr_idx,
	output logic       error_flag
);

	logic   instr_valid;
	instr_t instr;
	logic   is_addsub_imm;
	logic   is_addsub_reg;
	logic   is_addsub;
	logic   is_logic_reg;
	logic   is_ldst;
	logic   is_b;
	logic   is_bcond;
	logic   is_nop;
	logic   known;
	word_t  imm_m;

	// First word arrives one run cycle after reset release
	assign instr = instr_valid ? instr_data : INST_NOP;

	// ------------------------------------------------------------------------
	// Class match
	// ------------------------------------------------------------------------
	assign is_addsub_imm = (instr & MASK_ADDSUB_IMM) == MATCH_ADDSUB_IMM;
	assign is_addsub_reg = (instr & MASK_ADDSUB_REG) == MATCH_ADDSUB_REG;
	assign is_addsub     = is_addsub_imm || is_addsub_reg;
	// opc 11 is ANDS
	assign is_logic_reg  = ((instr & MASK_LOGIC_REG) == MATCH_LOGIC_REG) &&
		(instr[30:29] != 2'b11);
	// Halfword size is left out
	assign is_ldst       = ((instr & MASK_LDST_UIMM) == MATCH_LDST_UIMM) &&
		(instr[31:30] inside {SIZE_B, SIZE_W, SIZE_D});
	assign is_b          = (instr & MASK_B) == MATCH_B;
	assign is_bcond      = (instr & MASK_BCOND) == MATCH_BCOND;
	assign is_nop        = instr == INST_NOP;
	assign known = is_addsub || is_logic_reg || is_ldst || is_b || is_bcond || is_nop;

	// Rn, Rm, and Rt/Rd as third port for store data
	assign rd_idx_n = instr[9:5];
	assign rd_idx_m = instr[20:16];
	assign rd_idx_a = instr[4:0];

	// M operand is the immediate or the register
	// Load/store offsets scale by access size and branch offsets by words
	assign imm_m = is_addsub_imm ? word_t'(instr[21:10]) :
		is_ldst  ? word_t'(instr[21:10]) << instr[31:30] :
		is_b     ? {{36{instr[25]}}, instr[25:0], 2'b00} :
		is_bcond ? {{43{instr[23]}}, instr[23:5], 2'b00} :
		rd_m;

	// ------------------------------------------------------------------------
	// Decode to execute registers
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			instr_valid <= 1'b0;
			error_flag  <= 1'b0;
			set_flags   <= 1'b0;
			is_branch   <= 1'b0;
			mem_read    <= 1'b0;
			mem_write   <= 1'b0;
			wr_en       <= 1'b0;
		end else if (run) begin
			instr_valid <= 1'b1;
			error_flag  <= error_flag || !known;
			// Undefined word leaves a bubble behind
			set_flags   <= is_addsub && instr[29];
			is_branch   <= is_b || is_bcond;
			mem_read    <= is_ldst && instr[22];
			mem_write   <= is_ldst && !instr[22];
			wr_en       <= is_addsub || is_logic_reg || (is_ldst && instr[22]);
		end
	end

	always_ff @(posedge clk) begin
		if (run) begin
			// Branch target is PC relative
			op_n     <= (is_b || is_bcond) ? fetch_pc : rd_n;
			op_m     <= imm_m;
			op_a     <= rd_a;
			alu_cmd  <= is_logic_reg ? alu_cmd_t'(instr[30:29]) : ALU_ADD;
			invert_b <= is_addsub && instr[30];
			// Addresses and targets are always full width
			sf       <= (is_addsub || is_logic_reg) ? instr[31] : 1'b1;
			cond     <= is_bcond ? instr[3:0] : COND_AL;
			mem_size <= instr[31:30];
			wr_idx   <= instr[4:0];
		end
	end

	// Load or store but never both, with a plain 64-bit address add
	a_mem_excl: assert property (@(posedge clk) disable iff (!nreset)
		(mem_read || mem_write) |-> (mem_read != mem_write) &&
		alu_cmd == ALU_ADD && !invert_b && sf);

	// Undefined word reaches execute as a bubble
	a_err_bubble: assert property (@(posedge clk) disable iff (!nreset)
		error_flag |-> !(mem_read || mem_write || wr_en || set_flags || is_branch));

endmodule

//--- verilog/reg_file.sv
/*
 * 31 general registers, three read ports, one write port.
 * Index 31 reads as zero and drops writes. A write in the same cycle is
 * passed through to the reads.
 */
`timescale 1ns/1ns

module reg_file import edu_core_pkg::*; (
	input  logic     clk,
	input  logic     run,
	input  reg_idx_t rd_idx_n,
	input  reg_idx_t rd_idx_m,
	input  reg_idx_t rd_idx_a,
	output word_t    rd_n,
	output word_t    rd_m,
	output word_t    rd_a,
	input  logic     wb_en,
	input  reg_idx_t wb_idx,
	input  word_t    wb_data
);

	word_t regs [0:30];

	// Zero register first, then write-through, then storage
	function automatic word_t read_port(input reg_idx_t idx);
		word_t value;
		if (idx == REG_ZERO) begin
			value = '0;
		end else if (wb_en && wb_idx == idx) begin
			value = wb_data;
		end else begin
			value = regs[idx];
		end
		return value;
	endfunction

	always_comb begin
		rd_n = read_port(rd_idx_n);
		rd_m = read_port(rd_idx_m);
		rd_a = read_port(rd_idx_a);
	end

	always_ff @(posedge clk) begin
		if (run && wb_en && wb_idx != REG_ZERO) begin
			regs[wb_idx] <= wb_data;
		end
	end

endmodule

//--- verilog/execute_stage.sv
/*
 * ALU, NZCV flags, condition check and the execute-to-memory registers.
 * One adder serves arithmetic, load/store addresses and branch targets.
 * With sf low the upper half is zeroed and flags come from bit 31.
 */
`timescale 1ns/1ns

module execute_stage import edu_core_pkg::*; (
	input  logic       clk,
	input  logic       nreset,
	input  logic       run,
	input  word_t      op_n,
	input  word_t      op_m,
	input  word_t      op_a,
	input  alu_cmd_t   alu_cmd,
	input  logic       invert_b,
	input  logic       sf,
	input  logic       set_flags,
	input  logic [3:0] cond,
	input  logic       is_branch,
	input  logic       mem_read,
	input  logic       mem_write,
	input  mem_size_t  mem_size,
	input  logic       wr_en,
	input  reg_idx_t   wr_idx,
	output logic       branch_taken,
	output word_t      branch_target,
	output word_t      mem_addr,
	output word_t      mem_wdata,
	output word_t      ex_result,
	output logic       ma_read,
	output logic       ma_write,
	output mem_size_t  ma_size,
	output logic       ma_wr_en,
	output reg_idx_t   ma_wr_idx
);

	word_t       b_op;
	logic [64:0] sum64;
	logic [32:0] sum32;
	word_t       alu_raw;
	word_t       alu_result;
	nzcv_t       alu_flags;
	nzcv_t       flags;
	logic        cond_ok;

	// ------------------------------------------------------------------------
	// ALU
	// ------------------------------------------------------------------------
	// Invert plus carry in gives subtraction
	assign b_op  = invert_b ? ~op_m : op_m;
	assign sum64 = {1'b0, op_n} + {1'b0, b_op} + 65'(invert_b);
	// Narrow sum only for the 32-bit carry
	assign sum32 = {1'b0, op_n[31:0]} + {1'b0, b_op[31:0]} + 33'(invert_b);

	always_comb begin
		case (alu_cmd)
			ALU_AND: alu_raw = op_n & b_op;
			ALU_ORR: alu_raw = op_n | b_op;
			ALU_EOR: alu_raw = op_n ^ b_op;
			default: alu_raw = sum64[63:0];
		endcase
	end

	assign alu_result = sf ? alu_raw : {32'b0, alu_raw[31:0]};

	// Overflow when operands agree in sign and the sum does not
	assign alu_flags[3] = sf ? alu_result[63] : alu_result[31];
	assign alu_flags[2] = alu_result == '0;
	assign alu_flags[1] = sf ? sum64[64] : sum32[32];
	assign alu_flags[0] = sf ?
		(op_n[63] == b_op[63]) && (sum64[63] != op_n[63]) :
		(op_n[31] == b_op[31]) && (sum32[31] != op_n[31]);

	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			flags <= '0;
		end else if (run && set_flags) begin
			flags <= alu_flags;
		end
	end

	// ------------------------------------------------------------------------
	// Condition check by the A64 table
	// ------------------------------------------------------------------------
	// cond[0] inverts all but AL and NV
	always_comb begin
		case (cond[3:1])
			3'b000:  cond_ok = flags[2];
			3'b001:  cond_ok = flags[1];
			3'b010:  cond_ok = flags[3];
			3'b011:  cond_ok = flags[0];
			3'b100:  cond_ok = flags[1] && !flags[2];
			3'b101:  cond_ok = flags[3] == flags[0];
			3'b110:  cond_ok = (flags[3] == flags[0]) && !flags[2];
			default: cond_ok = 1'b1;
		endcase
		if (cond[0] && cond[3:1] != 3'b111) begin
			cond_ok = !cond_ok;
		end
	end

	assign branch_taken  = is_branch && cond_ok;
	// op_n holds the branch PC here
	assign branch_target = alu_result;

	// ------------------------------------------------------------------------
	// Execute to memory registers
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			ma_read  <= 1'b0;
			ma_write <= 1'b0;
			ma_wr_en <= 1'b0;
		end else if (run) begin
			ma_read  <= mem_read;
			ma_write <= mem_write;
			ma_wr_en <= wr_en;
		end
	end

	always_ff @(posedge clk) begin
		if (run) begin
			ex_result <= alu_result;
			mem_wdata <= op_a;
			ma_size   <= mem_size;
			ma_wr_idx <= wr_idx;
		end
	end

	// Load/store address is the ALU sum
	assign mem_addr = ex_result;

	// Taken branch uses a plain 64-bit add and makes no write or access
	a_branch_only: assert property (@(posedge clk) disable iff (!nreset)
		branch_taken |-> alu_cmd == ALU_ADD && !invert_b && sf &&
		!wr_en && !mem_read && !mem_write);

endmodule

//--- verilog/mem_wb_stage.sv
/*
 * Memory port drive and writeback. Strobes are held while run is low.
 * data_rdata is expected in the cycle after data_read.
 * Loads zero-extend by size.
 */
`timescale 1ns/1ns

module mem_wb_stage import edu_core_pkg::*; (
	input  logic      clk,
	input  logic      nreset,
	input  logic      run,
	input  word_t     mem_addr,
	input  word_t     mem_wdata,
	input  word_t     ex_result,
	input  logic      ma_read,
	input  logic      ma_write,
	input  mem_size_t ma_size,
	input  logic      ma_wr_en,
	input  reg_idx_t  ma_wr_idx,
	output word_t     data_addr,
	output word_t     data_wdata,
	output mem_size_t data_size,
	output logic      data_read,
	output logic      data_write,
	input  word_t     data_rdata,
	output logic      wb_en,
	output reg_idx_t  wb_idx,
	output word_t     wb_data
);

	logic      wb_load;
	mem_size_t wb_size;
	word_t     wb_result;
	word_t     load_value;

	// Memory stage outputs
	assign data_addr  = mem_addr;
	assign data_wdata = mem_wdata;
	assign data_size  = ma_size;
	assign data_read  = ma_read;
	assign data_write = ma_write;

	// ------------------------------------------------------------------------
	// Memory to writeback registers
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge nreset) begin
		if (!nreset) begin
			wb_en   <= 1'b0;
			wb_load <= 1'b0;
		end else if (run) begin
			wb_en   <= ma_wr_en;
			wb_load <= ma_read;
		end
	end

	always_ff @(posedge clk) begin
		if (run) begin
			wb_idx    <= ma_wr_idx;
			wb_size   <= ma_size;
			wb_result <= ex_result;
		end
	end

	// Zero extension of the loaded value
	always_comb begin
		case (wb_size)
			SIZE_B:  load_value = {56'b0, data_rdata[7:0]};
			SIZE_W:  load_value = {32'b0, data_rdata[31:0]};
			default: load_value = data_rdata;
		endcase
	end

	assign wb_data = wb_load ? load_value : wb_result;

endmodule

//--- verilog/edu_core.sv
/*
 * Five-stage in-order core for a small A64 subset. There is no hazard logic.
 * A result is visible to the third instruction after its producer.
 * Two delay slots follow every branch. clk_en low freezes the whole core.
 * instr_data and data_rdata come from synchronous memories, one cycle late.
 */
`timescale 1ns/1ns

module edu_core import edu_core_pkg::*; (
	input  logic      clk,
	input  logic      nreset,
	input  logic      clk_en,
	output word_t     instr_addr,
	output logic      instr_en,
	input  instr_t    instr_data,
	output word_t     data_addr,
	output word_t     data_wdata,
	output mem_size_t data_size,
	output logic      data_read,
	output logic      data_write,
	input  word_t     data_rdata,
	output logic      error_flag
);

	// Core enable and fetch to decode
	logic       run;
	word_t      pc;
	logic       branch_taken;
	word_t      branch_target;

	// Register file read ports
	reg_idx_t   rd_idx_n;
	reg_idx_t   rd_idx_m;
	reg_idx_t   rd_idx_a;
	word_t      rd_n;
	word_t      rd_m;
	word_t      rd_a;

	// Decode to execute
	word_t      op_n;
	word_t      op_m;
	word_t      op_a;
	alu_cmd_t   alu_cmd;
	logic       invert_b;
	logic       sf;
	logic       set_flags;
	logic [3:0] cond;
	logic       is_branch;
	logic       mem_read;
	logic       mem_write;
	mem_size_t  mem_size;
	logic       wr_en;
	reg_idx_t   wr_idx;

	// Execute to memory
	word_t      mem_addr;
	word_t      mem_wdata;
	word_t      ex_result;
	logic       ma_read;
	logic       ma_write;
	mem_size_t  ma_size;
	logic       ma_wr_en;
	reg_idx_t   ma_wr_idx;

	// Writeback into the register file
	logic       wb_en;
	reg_idx_t   wb_idx;
	word_t      wb_data;

	// Port names match the wires above
	fetch_stage u_fetch (.*);

	decode_stage u_decode (
		.fetch_pc(pc),
		.*
	);

	reg_file u_regs (.*);

	execute_stage u_execute (.*);

	mem_wb_stage u_mem_wb (.*);

endmodule

//--- sim/edu_core_tb.sv
/*
 * Testbench for the five-stage core. Programs are built in memory at time zero.
 * Two NOPs follow every instruction, so no result or branch hazard is exposed.
 * Stores are predicted by an instruction-level model and compared in order.
 * Data memory covers 4 KB and instruction memory 1024 words, both wrapping.
 */
`timescale 1ns/1ns

module edu_core_tb import edu_core_pkg::*; ();

	logic      clk;
	logic      nreset;
	logic      clk_en;
	word_t     instr_addr;
	logic      instr_en;
	instr_t    instr_data;
	word_t     data_addr;
	word_t     data_wdata;
	mem_size_t data_size;
	logic      data_read;
	logic      data_write;
	word_t     data_rdata;
	logic      error_flag;

	// Memories seen by the DUT
	instr_t     imem [0:1023];
	logic [7:0] dmem [0:4095];
	// Saved programs, copied into imem per phase
	instr_t     main_prog [0:1023];
	instr_t     err_prog [0:1023];
	int         prog_len;
	int         main_len;
	int         err_len;

	// Reference model state
	word_t      ref_regs [0:30];
	nzcv_t      ref_flags;
	logic [7:0] ref_mem [0:4095];
	word_t      q_addr [$];
	word_t      q_data [$];
	mem_size_t  q_size [$];

	logic [31:0] lfsr_state;
	logic        stall_mode;
	logic        error_low;
	int          value_errs;
	int          event_errs;
	int          cycles;
	int          limit;

	edu_core uut (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// Random numbers, compare tasks
	// ------------------------------------------------------------------------
	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] value;
		logic        lsb;
		value = '0;
		for (int i = 0; i < n; i++) begin
			lsb        = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (lsb) begin
				lfsr_state = lfsr_state ^ 32'h8020_0003;
			end
			value = {value[30:0], lsb};
		end
		return value;
	endfunction

	task automatic check_word(input word_t got, input word_t exp, input string msg);
		if (got !== exp) begin
			value_errs++;
			$display("ERR %0t: %s is %h, expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic check_size(input mem_size_t got, input mem_size_t exp, input string msg);
		if (got !== exp) begin
			value_errs++;
			$display("ERR %0t: %s is %b, expected %b", $time, msg, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string msg);
		if (got !== exp) begin
			value_errs++;
			$display("ERR %0t: %s is %b, expected %b", $time, msg, got, exp);
		end
	endtask

	// ------------------------------------------------------------------------
	// Instruction encodings
	// ------------------------------------------------------------------------
	function automatic instr_t addsub_imm_word(input logic sf, input logic sub, input logic s,
		input logic [11:0] imm, input reg_idx_t rn, input reg_idx_t rd);
		return {sf, sub, s, 6'b100010, 1'b0, imm, rn, rd};
	endfunction

	function automatic instr_t addsub_reg_word(input logic sf, input logic sub, input logic s,
		input reg_idx_t rm, input reg_idx_t rn, input reg_idx_t rd);
		return {sf, sub, s, 5'b01011, 3'b000, rm, 6'b0, rn, rd};
	endfunction

	// opc 00 AND, 01 ORR, 10 EOR
	function automatic instr_t logic_reg_word(input logic sf, input logic [1:0] opc,
		input reg_idx_t rm, input reg_idx_t rn, input reg_idx_t rd);
		return {sf, opc, 5'b01010, 3'b000, rm, 6'b0, rn, rd};
	endfunction

	// Offset in units of the access size
	function automatic instr_t ldst_word(input mem_size_t size, input logic load,
		input logic [11:0] imm, input reg_idx_t rn, input reg_idx_t rt);
		return {size, 6'b111001, 1'b0, load, imm, rn, rt};
	endfunction

	function automatic instr_t branch_word(input logic [25:0] off);
		return {6'b000101, off};
	endfunction

	function automatic instr_t bcond_word(input logic [18:0] off, input logic [3:0] cond);
		return {8'h54, off, 1'b0, cond};
	endfunction

	// Instruction plus two NOPs
	function automatic void place(input instr_t w);
		imem[10'(prog_len)]     = w;
		imem[10'(prog_len + 1)] = INST_NOP;
		imem[10'(prog_len + 2)] = INST_NOP;
		prog_len += 3;
	endfunction

	// Low byte mixed with the upper address bits
	function automatic logic [7:0] fill_byte(input int a);
		return 8'(a) ^ 8'(a >> 4) ^ 8'h5a;
	endfunction

	// ------------------------------------------------------------------------
	// Program builders
	// ------------------------------------------------------------------------
	function automatic void build_main();
		int          slot;
		logic [2:0]  kind;
		logic        sf;
		reg_idx_t    rd;
		reg_idx_t    rn;
		reg_idx_t    rm;
		mem_size_t   sizes [3];
		slot     = 0;
		prog_len = 0;
		sizes    = '{SIZE_B, SIZE_W, SIZE_D};
		for (int i = 0; i < 1024; i++) begin
			imem[10'(i)] = INST_NOP;
		end
		// Every register gets a defined value first
		for (int r = 0; r < 31; r++) begin
			place(addsub_imm_word(1'b1, 1'b0, 1'b0, 12'(rand_bits(12)), 5'd31, 5'(r)));
		end
		// Random ALU operations, each result stored
		for (int k = 0; k < 40; k++) begin
			kind = 3'(rand_bits(3));
			sf   = rand_bits(1) != 0;
			rd   = 5'(rand_bits(5));
			rn   = 5'(rand_bits(5));
			rm   = 5'(rand_bits(5));
			if (kind < 3'd4) begin
				place(addsub_imm_word(sf, kind[0], kind[1], 12'(rand_bits(12)), rn, rd));
			end else if (kind == 3'd4) begin
				place(addsub_reg_word(sf, rand_bits(1) != 0, rand_bits(1) != 0, rm, rn, rd));
			end else begin
				place(logic_reg_word(sf, 2'(kind - 3'd5), rm, rn, rd));
			end
			place(ldst_word(SIZE_D, 1'b0, 12'(slot), 5'd31, rd));
			slot++;
		end
		// Compare then branch over one store
		for (int c = 0; c < 15; c++) begin
			rn = 5'(rand_bits(5));
			rm = (rand_bits(1) != 0) ? rn : 5'(rand_bits(5));
			place(addsub_reg_word(rand_bits(1) != 0, 1'b1, 1'b1, rm, rn, 5'd31));
			place(bcond_word(19'd6, 4'(c)));
			place(ldst_word(SIZE_D, 1'b0, 12'(slot), 5'd31, 5'd1));
			place(ldst_word(SIZE_D, 1'b0, 12'(slot + 1), 5'd31, 5'd1));
			slot += 2;
		end
		// Store, reload and store again per size
		for (int j = 0; j < 3; j++) begin
			rn = 5'(rand_bits(5));
			rd = 5'(rand_bits(5) % 31);
			place(ldst_word(sizes[j], 1'b0, 12'((slot * 8) >> sizes[j]), 5'd31, rn));
			place(ldst_word(sizes[j], 1'b1, 12'((slot * 8) >> sizes[j]), 5'd31, rd));
			place(ldst_word(SIZE_D, 1'b0, 12'(slot + 1), 5'd31, rd));
			slot += 2;
		end
		// Branch to itself ends the program
		place(branch_word(26'd0));
	endfunction

	function automatic void build_err();
		prog_len = 0;
		for (int i = 0; i < 1024; i++) begin
			imem[10'(i)] = INST_NOP;
		end
		place(addsub_imm_word(1'b1, 1'b0, 1'b0, 12'h5a5, 5'd31, 5'd1));
		place(ldst_word(SIZE_D, 1'b0, 12'd0, 5'd31, 5'd1));
		// Undefined encoding, the store after it must never happen
		place(32'h0000_0000);
		place(ldst_word(SIZE_D, 1'b0, 12'd1, 5'd31, 5'd1));
		place(branch_word(26'd0));
	endfunction

	// ------------------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------------------
	function automatic word_t read_reg(input reg_idx_t r);
		return (r == 5'd31) ? word_t'(0) : ref_regs[r];
	endfunction

	function automatic void write_reg(input reg_idx_t r, input word_t v);
		if (r != 5'd31) begin
			ref_regs[r] = v;
		end
	endfunction

	// A64 condition table over N, Z, C, V
	function automatic logic cond_holds(input logic [3:0] cond);
		logic n;
		logic z;
		logic c;
		logic v;
		logic ok;
		{n, z, c, v} = ref_flags;
		case (cond[3:1])
			3'd0:    ok = z;
			3'd1:    ok = c;
			3'd2:    ok = n;
			3'd3:    ok = v;
			3'd4:    ok = c && !z;
			3'd5:    ok = n == v;
			3'd6:    ok = !z && (n == v);
			default: ok = 1'b1;
		endcase
		if (cond[0] && cond != 4'b1111) begin
			ok = !ok;
		end
		return ok;
	endfunction

	function automatic void do_arith(input logic sf, input logic sub, input logic s,
		input word_t a, input word_t b_in, input reg_idx_t rd);
		word_t       b;
		word_t       res;
		logic [64:0] s64;
		logic [32:0] s32;
		b   = sub ? ~b_in : b_in;
		s64 = {1'b0, a} + {1'b0, b} + 65'(sub);
		s32 = {1'b0, a[31:0]} + {1'b0, b[31:0]} + 33'(sub);
		res = sf ? s64[63:0] : {32'b0, s32[31:0]};
		if (s) begin
			ref_flags[3] = sf ? res[63] : res[31];
			ref_flags[2] = res == '0;
			ref_flags[1] = sf ? s64[64] : s32[32];
			ref_flags[0] = sf ? (a[63] == b[63]) && (res[63] != a[63]) :
				(a[31] == b[31]) && (res[31] != a[31]);
		end
		write_reg(rd, res);
	endfunction

	// Executes one word, returns the next index or -1 to stop
	function automatic int ref_exec(input instr_t ins, input int idx);
		word_t     a;
		word_t     b;
		word_t     res;
		word_t     addr;
		word_t     val;
		mem_size_t size;
		int        nbytes;
		int        next;
		next = idx + 1;
		a    = read_reg(ins[9:5]);
		b    = read_reg(ins[20:16]);
		if (ins == INST_NOP) begin
			next = idx + 1;
		end else if (ins[28:23] == 6'b100010 && !ins[22]) begin
			do_arith(ins[31], ins[30], ins[29], a, word_t'(ins[21:10]), ins[4:0]);
		end else if (ins[28:24] == 5'b01011) begin
			do_arith(ins[31], ins[30], ins[29], a, b, ins[4:0]);
		end else if (ins[28:24] == 5'b01010) begin
			case (ins[30:29])
				2'b00:   res = a & b;
				2'b01:   res = a | b;
				default: res = a ^ b;
			endcase
			write_reg(ins[4:0], ins[31] ? res : {32'b0, res[31:0]});
		end else if (ins[29:24] == 6'b111001) begin
			size   = ins[31:30];
			nbytes = 1 << size;
			addr   = a + (word_t'(ins[21:10]) << size);
			if (ins[22]) begin
				val = '0;
				for (int i = 0; i < nbytes; i++) begin
					val = val | (word_t'(ref_mem[12'(addr + word_t'(i))]) << (8 * i));
				end
				write_reg(ins[4:0], val);
			end else begin
				val = read_reg(ins[4:0]);
				q_addr.push_back(addr);
				q_data.push_back(val);
				q_size.push_back(size);
				for (int i = 0; i < nbytes; i++) begin
					ref_mem[12'(addr + word_t'(i))] = 8'(val >> (8 * i));
				end
			end
		end else if (ins[31:26] == 6'b000101) begin
			// Delay slots are NOPs, so jumping at once is equivalent
			next = (ins[25:0] == '0) ? -1 : idx + int'({{6{ins[25]}}, ins[25:0]});
		end else if (ins[31:24] == 8'h54) begin
			if (cond_holds(ins[3:0])) begin
				next = idx + int'({{13{ins[23]}}, ins[23:5]});
			end
		end else begin
			next = -1;
		end
		return next;
	endfunction

	function automatic void run_model();
		int idx;
		int steps;
		idx       = 0;
		steps     = 0;
		ref_flags = '0;
		q_addr.delete();
		q_data.delete();
		q_size.delete();
		for (int i = 0; i < 31; i++) begin
			ref_regs[i] = '0;
		end
		for (int i = 0; i < 4096; i++) begin
			ref_mem[12'(i)] = fill_byte(i);
		end
		while (idx >= 0 && steps < 4096) begin
			idx = ref_exec(imem[10'(idx)], idx);
			steps++;
		end
	endfunction

	// ------------------------------------------------------------------------
	// Memory models
	// ------------------------------------------------------------------------
	always @(posedge clk) begin
		if (clk_en && instr_en) begin
			instr_data <= imem[instr_addr[11:2]];
		end
	end

	always @(posedge clk) begin
		word_t v;
		if (clk_en && data_read) begin
			v = '0;
			for (int i = 0; i < 8; i++) begin
				v = v | (word_t'(dmem[12'(data_addr + word_t'(i))]) << (8 * i));
			end
			data_rdata <= v;
		end
		if (clk_en && data_write) begin
			for (int i = 0; i < (1 << data_size); i++) begin
				dmem[12'(data_addr + word_t'(i))] = 8'(data_wdata >> (8 * i));
			end
		end
	end

	// Store stream and error flag against the model
	always @(posedge clk) begin
		if (nreset && clk_en && data_write) begin
			if (q_addr.size() == 0) begin
				event_errs++;
				$display("Unexpected store to address %h at %0t", data_addr, $time);
			end else begin
				check_word(data_addr, q_addr.pop_front(), "store address");
				check_word(data_wdata, q_data.pop_front(), "store data");
				check_size(data_size, q_size.pop_front(), "store size");
			end
		end
		if (nreset && error_low) begin
			check_flag(error_flag, 1'b0, "error_flag");
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (limit != 0 && cycles >= limit) begin
			$display("Timeout after %0d cycles with %0d stores missing", cycles, q_addr.size());
			$display("Test failed");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// Sequencing
	// ------------------------------------------------------------------------
	task automatic tick();
		@(posedge clk);
		#10;
		if (stall_mode) begin
			clk_en = rand_bits(2) != 0;
		end else begin
			clk_en = 1'b1;
		end
	endtask

	task automatic load_program(input logic use_err);
		for (int i = 0; i < 1024; i++) begin
			imem[10'(i)] = use_err ? err_prog[10'(i)] : main_prog[10'(i)];
		end
	endtask

	// Reset for two cycles, then the state right after release
	task automatic apply_reset();
		@(posedge clk);
		#10;
		nreset = 1'b0;
		clk_en = 1'b1;
		for (int i = 0; i < 4096; i++) begin
			dmem[12'(i)] = fill_byte(i);
		end
		repeat (2) @(posedge clk);
		#10;
		nreset = 1'b1;
		check_flag(data_read, 1'b0, "data_read after reset");
		check_flag(data_write, 1'b0, "data_write after reset");
		check_flag(error_flag, 1'b0, "error_flag after reset");
		check_flag(instr_en, 1'b0, "instr_en in reset");
		tick();
		check_flag(instr_en, 1'b1, "instr_en after release");
		check_word(instr_addr, word_t'(0), "first fetch address");
	endtask

	task automatic drain_stores();
		while (q_addr.size() != 0) begin
			tick();
		end
		repeat (8) tick();
	endtask

	initial begin
		nreset     = 1'b0;
		clk_en     = 1'b1;
		instr_data = INST_NOP;
		data_rdata = '0;
		lfsr_state = 32'h50cb_c188;
		stall_mode = 1'b0;
		error_low  = 1'b0;
		value_errs = 0;
		event_errs = 0;
		cycles     = 0;
		limit      = 0;

		build_main();
		main_len = prog_len;
		for (int i = 0; i < 1024; i++) begin
			main_prog[10'(i)] = imem[10'(i)];
		end
		build_err();
		err_len = prog_len;
		for (int i = 0; i < 1024; i++) begin
			err_prog[10'(i)] = imem[10'(i)];
		end
		limit = 4 * (2 * main_len + err_len) + 100;

		// ALU, branches and load/store sizes with clk_en high
		load_program(1'b0);
		run_model();
		apply_reset();
		error_low = 1'b1;
		drain_stores();

		// Same program under random stalls
		load_program(1'b0);
		run_model();
		error_low = 1'b0;
		apply_reset();
		error_low  = 1'b1;
		stall_mode = 1'b1;
		drain_stores();
		stall_mode = 1'b0;

		// Undefined word stops the core for good
		load_program(1'b1);
		run_model();
		error_low = 1'b0;
		apply_reset();
		while (!error_flag) begin
			tick();
		end
		repeat (20) begin
			tick();
			check_flag(error_flag, 1'b1, "error_flag held");
		end
		if (q_addr.size() != 0) begin
			event_errs++;
			$display("Stores before the undefined word missing: %0d", q_addr.size());
		end

		$display("Errors: %0d value, %0d other", value_errs, event_errs);
		if (value_errs + event_errs == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- edu_core.f
verilog/edu_core_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/reg_file.sv
verilog/execute_stage.sv
verilog/mem_wb_stage.sv
verilog/edu_core.sv
sim/edu_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the core and its testbench with Verilator and runs the simulation.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module edu_core_tb -f edu_core.f -o edu_core_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/edu_core_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Test completed successfully"; then
	exit 0
fi
exit 1
